// ==== hdl/c1_consts.svh ====
`ifndef C1_CONSTS_SVH
`define C1_CONSTS_SVH

// Field widths
`define C1_ADDR_W 8   // CPU address bits 23..16
`define C1_JOY_W 10   // Directions plus buttons
`define C1_WAIT_W 2

// Zone codes on address bits 23..19
`define C1_ZONE_ROM  5'b00000
`define C1_ZONE_WRAM 5'b00001
`define C1_ZONE_PORT 5'b00010
`define C1_ZONE_IO   5'b00011
`define C1_ZONE_SROM 5'b11000
`define C1_ZONE_SRAM 5'b11001

// Quarter-space zones, only bits 23..22 matter
`define C1_ZONE_PAL  2'b01
`define C1_ZONE_CARD 2'b10

// Wait states for a slow program ROM
`define C1_ROM_WAIT 1

// Arcade cabinet by default
`define C1_CONSOLE_MODE 1'b1

// Register select codes
`define C1_SEL_CTRL1   2'd0
`define C1_SEL_ICOM    2'd1
`define C1_SEL_CTRL2   2'd2
`define C1_SEL_STATUSB 2'd3

`endif

// ==== hdl/c1Pkg.sv ====
`default_nettype none

`include "c1_consts.svh"

package c1Pkg;

	// Upper CPU address, bits 23..16
	typedef logic [`C1_ADDR_W-1:0] addrHi_t;

	// One byte lane of the data bus
	typedef logic [7:0] byte_t;

	// Joypad group, active low
	// Bits 7..0 go to the CTRL registers, 9..8 to STATUSB
	typedef logic [`C1_JOY_W-1:0] joy_t;

	typedef logic [`C1_WAIT_W-1:0] waitCnt_t;

	// DTACK generator states
	typedef enum logic [1:0] {
		IDLE,   // No cycle in progress
		COUNT,  // Burning wait states
		ACK,    // Ready, waiting on port back-pressure
		HOLD    // nDtack low until nAs rises
	} waitState_t;

endpackage

`default_nettype wire

// ==== hdl/c1Decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c1_consts.svh"

module c1Decode import c1Pkg::*; (
	input  addrHi_t    m68kAddr,
	input  logic       rw,
	input  logic       nAs,
	input  logic       nUds,
	input  logic       nLds,
	output logic       nRomOeL,
	output logic       nRomOeU,
	output logic       nPortOeL,
	output logic       nPortOeU,
	output logic       nPortWeL,
	output logic       nPortWeU,
	output logic       nPortAdrs,
	output logic       nWrL,
	output logic       nWrU,
	output logic       nWwL,
	output logic       nWwU,
	output logic       nSromOeL,
	output logic       nSromOeU,
	output logic       nSramOeL,
	output logic       nSramOeU,
	output logic       nSramWeL,
	output logic       nSramWeU,
	output logic       nLspOe,
	output logic       nLspWe,
	output logic       nCrdO,
	output logic       nCrdW,
	output logic       nCrdC,
	output logic       nDipRd0,
	output logic       nDipRd1,
	output logic       nBitW0,
	output logic       nBitW1,
	output logic       nPal,
	output logic [1:0] regSel,
	output logic       regHit,
	output logic       romZone,
	output logic       portZone
);

	logic [4:0] zoneCode;
	logic [2:0] ioSub;
	logic wramZone;
	logic ioZone;
	logic palZone;
	logic cardZone;
	logic sromZone;
	logic sramZone;
	logic lspZone;
	logic anyStrobe;
	logic rdL;
	logic rdU;
	logic wrL;
	logic wrU;
	logic rdWord;
	logic wrWord;
	logic subHit;

	assign zoneCode = m68kAddr[7:3];
	assign ioSub = m68kAddr[2:0];  // I/O subzone, bits 18..16

	assign romZone  = (zoneCode == `C1_ZONE_ROM);
	assign wramZone = (zoneCode == `C1_ZONE_WRAM);
	assign portZone = (zoneCode == `C1_ZONE_PORT);
	assign ioZone   = (zoneCode == `C1_ZONE_IO);
	assign sromZone = (zoneCode == `C1_ZONE_SROM);
	assign sramZone = (zoneCode == `C1_ZONE_SRAM);
	assign palZone  = (m68kAddr[7:6] == `C1_ZONE_PAL);
	assign cardZone = (m68kAddr[7:6] == `C1_ZONE_CARD);
	assign lspZone  = ioZone & (ioSub == 3'b110);  // Video controller

	// Byte lane qualifiers, all dead while nAs is high
	assign anyStrobe = ~nAs & ~(nUds & nLds);
	assign rdL = ~nAs & rw & ~nLds;
	assign rdU = ~nAs & rw & ~nUds;
	assign wrL = ~nAs & ~rw & ~nLds;
	assign wrU = ~nAs & ~rw & ~nUds;
	assign rdWord = rdL & rdU;  // Word-only devices
	assign wrWord = wrL & wrU;

	assign nRomOeL  = ~(romZone & rdL);
	assign nRomOeU  = ~(romZone & rdU);
	assign nWrL     = ~(wramZone & rdL);
	assign nWrU     = ~(wramZone & rdU);
	assign nWwL     = ~(wramZone & wrL);
	assign nWwU     = ~(wramZone & wrU);
	assign nPortOeL = ~(portZone & rdL);
	assign nPortOeU = ~(portZone & rdU);
	assign nPortWeL = ~(portZone & wrL);
	assign nPortWeU = ~(portZone & wrU);
	assign nPortAdrs = ~(portZone & anyStrobe);  // Address latch for the cartridge
	assign nSromOeL = ~(sromZone & rdL);
	assign nSromOeU = ~(sromZone & rdU);
	assign nSramOeL = ~(sramZone & rdL);
	assign nSramOeU = ~(sramZone & rdU);
	assign nSramWeL = ~(sramZone & wrL);
	assign nSramWeU = ~(sramZone & wrU);
	assign nPal     = ~(palZone & anyStrobe);

	assign nLspOe = ~(lspZone & rdWord);
	assign nLspWe = ~(lspZone & wrWord);
	assign nCrdO  = ~(cardZone & rdWord);
	assign nCrdW  = ~(cardZone & wrWord);
	assign nCrdC  = nCrdO & nCrdW;  // Card enable on either direction

	// Odd-byte ports of the I/O zone
	assign nDipRd0 = ~(ioZone & rdL & (ioSub == 3'b000));
	assign nDipRd1 = ~(ioZone & rdL & (ioSub == 3'b001));
	assign nBitW0  = ~(ioZone & wrL & (ioSub == 3'b100));
	assign nBitW1  = ~(ioZone & wrL & (ioSub == 3'b101));

	// Even-byte register select
	always_comb begin
		regSel = `C1_SEL_CTRL1;
		subHit = 1'b0;
		case (ioSub)
			3'b000: begin
				regSel = `C1_SEL_CTRL1;
				subHit = 1'b1;
			end
			3'b001: begin
				regSel = `C1_SEL_ICOM;
				subHit = 1'b1;
			end
			3'b010, 3'b011: begin  // CTRL2 spans two subzones
				regSel = `C1_SEL_CTRL2;
				subHit = 1'b1;
			end
			3'b100: begin
				regSel = `C1_SEL_STATUSB;
				subHit = 1'b1;
			end
			default: subHit = 1'b0;
		endcase
	end

	// Only ICOM accepts writes
	assign regHit = ioZone & ~nAs & ~nUds & subHit & (rw | (regSel == `C1_SEL_ICOM));

endmodule

`default_nettype wire

// ==== hdl/c1Regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c1_consts.svh"

module c1Regs import c1Pkg::*; #(
	parameter bit consoleMode = `C1_CONSOLE_MODE
) (
	input  logic       clk68k,
	input  logic       rst,
	input  logic [1:0] regSel,
	input  logic       regHit,
	input  logic       rw,
	input  byte_t      m68kDataIn,
	input  joy_t       p1In,
	input  joy_t       p2In,
	input  logic       nCd1,
	input  logic       nCd2,
	input  logic       nWp,
	input  byte_t      soundReply,
	output byte_t      m68kDataOut,
	output logic       m68kDataOe,
	output byte_t      soundCmd
);

	localparam int syncW = 2 * `C1_JOY_W + 3;

	logic [syncW-1:0] syncMeta;
	logic [syncW-1:0] syncOut;
	joy_t p1Sync;
	joy_t p2Sync;
	logic nCd1Sync;
	logic nCd2Sync;
	logic nWpSync;
	logic cmdWr;
	logic cmdDone;
	byte_t statusB;

	// Two-stage synchronizer for all board inputs
	always_ff @(posedge clk68k) begin
		syncMeta <= {p1In, p2In, nCd1, nCd2, nWp};
		syncOut <= syncMeta;
	end

	assign {p1Sync, p2Sync, nCd1Sync, nCd2Sync, nWpSync} = syncOut;

	assign cmdWr = regHit & ~rw & (regSel == `C1_SEL_ICOM);

	// Latch once per bus cycle, regHit drops with nAs
	always_ff @(posedge clk68k) begin
		if (rst) begin
			soundCmd <= '0;
			cmdDone <= 1'b0;
		end else begin
			cmdDone <= cmdWr;
			if (cmdWr && !cmdDone)
				soundCmd <= m68kDataIn;
		end
	end

	assign statusB = {consoleMode, nWpSync, nCd2Sync, nCd1Sync,
		p2Sync[`C1_JOY_W-1 -: 2], p1Sync[`C1_JOY_W-1 -: 2]};  // Start and select bits

	always_comb begin
		case (regSel)
			`C1_SEL_CTRL1:   m68kDataOut = p1Sync[7:0];
			`C1_SEL_ICOM:    m68kDataOut = soundReply;
			`C1_SEL_CTRL2:   m68kDataOut = p2Sync[7:0];
			default:         m68kDataOut = statusB;
		endcase
	end

	assign m68kDataOe = regHit & rw;

endmodule

`default_nettype wire

// ==== hdl/c1Wait.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c1_consts.svh"

module c1Wait import c1Pkg::*; (
	input  logic clk68k,
	input  logic rst,
	input  logic nAs,
	input  logic romZone,
	input  logic portZone,
	input  logic nRomWait,
	input  logic nPWait0,
	input  logic nPWait1,
	input  logic pDtack,
	output logic nDtack
);

	waitState_t state;
	waitCnt_t cnt;
	waitCnt_t waitN;
	logic portCyc;  // Cycle started in the port zone

	// Wait count for the cycle about to start
	always_comb begin
		if (romZone && !nRomWait)
			waitN = waitCnt_t'(`C1_ROM_WAIT);
		else if (portZone)
			waitN = ~{nPWait1, nPWait0};
		else
			waitN = '0;
	end

	always_ff @(posedge clk68k) begin
		if (rst) begin
			state <= IDLE;
			cnt <= '0;
			portCyc <= 1'b0;
			nDtack <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					if (!nAs) begin
						cnt <= waitN;
						portCyc <= portZone;
						// No wait states, acknowledge on the next edge
						if (waitN == '0)
							state <= ACK;
						else
							state <= COUNT;
					end
				end
				COUNT: begin
					if (nAs) begin
						state <= IDLE;  // Aborted cycle
					end else begin
						cnt <= cnt - 1'b1;
						if (cnt == waitCnt_t'(1))
							state <= ACK;
					end
				end
				ACK: begin
					if (nAs) begin
						state <= IDLE;
					end else if (!(portCyc && !pDtack)) begin  // Cartridge back-pressure
						nDtack <= 1'b0;
						state <= HOLD;
					end
				end
				HOLD: begin
					if (nAs) begin
						nDtack <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/neoC1.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "c1_consts.svh"

module neoC1 import c1Pkg::*; #(
	parameter bit consoleMode = `C1_CONSOLE_MODE
) (
	input  logic    clk68k,
	input  logic    rst,
	input  addrHi_t m68kAddr,
	input  logic    rw,
	input  logic    nAs,
	input  logic    nUds,
	input  logic    nLds,
	input  byte_t   m68kDataIn,
	output byte_t   m68kDataOut,
	output logic    m68kDataOe,
	output logic    nDtack,
	output logic    nRomOeL,
	output logic    nRomOeU,
	output logic    nPortOeL,
	output logic    nPortOeU,
	output logic    nPortWeL,
	output logic    nPortWeU,
	output logic    nPortAdrs,
	output logic    nWrL,
	output logic    nWrU,
	output logic    nWwL,
	output logic    nWwU,
	output logic    nSromOeL,
	output logic    nSromOeU,
	output logic    nSramOeL,
	output logic    nSramOeU,
	output logic    nSramWeL,
	output logic    nSramWeU,
	output logic    nLspOe,
	output logic    nLspWe,
	output logic    nCrdO,
	output logic    nCrdW,
	output logic    nCrdC,
	output logic    nDipRd0,
	output logic    nDipRd1,
	output logic    nBitW0,
	output logic    nBitW1,
	output logic    nPal,
	input  joy_t    p1In,
	input  joy_t    p2In,
	input  logic    nCd1,
	input  logic    nCd2,
	input  logic    nWp,
	input  byte_t   soundReply,
	output byte_t   soundCmd,
	input  logic    nRomWait,
	input  logic    nPWait0,
	input  logic    nPWait1,
	input  logic    pDtack
);

	logic [1:0] regSel;
	logic regHit;
	logic romZone;
	logic portZone;

	c1Decode c1Decode_i (
		.m68kAddr, .rw, .nAs, .nUds, .nLds,
		.nRomOeL, .nRomOeU, .nPortOeL, .nPortOeU, .nPortWeL, .nPortWeU, .nPortAdrs,
		.nWrL, .nWrU, .nWwL, .nWwU,
		.nSromOeL, .nSromOeU, .nSramOeL, .nSramOeU, .nSramWeL, .nSramWeU,
		.nLspOe, .nLspWe, .nCrdO, .nCrdW, .nCrdC,
		.nDipRd0, .nDipRd1, .nBitW0, .nBitW1, .nPal,
		.regSel, .regHit, .romZone, .portZone
	);

	// Even-byte registers on the upper data lane
	c1Regs #(
		.consoleMode(consoleMode)
	) c1Regs_i (
		.clk68k, .rst, .regSel, .regHit, .rw, .m68kDataIn,
		.p1In, .p2In, .nCd1, .nCd2, .nWp, .soundReply,
		.m68kDataOut, .m68kDataOe, .soundCmd
	);

	c1Wait c1Wait_i (
		.clk68k, .rst, .nAs, .romZone, .portZone,
		.nRomWait, .nPWait0, .nPWait1, .pDtack,
		.nDtack
	);

endmodule

`default_nettype wire

// ==== dv/neoC1_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module neoC1_chk (
	input wire logic clk68k,
	input wire logic rst,
	input wire logic nAs,
	input wire logic rw,
	input wire logic nDtack,
	input wire logic m68kDataOe,
	input wire logic nPortOeL,
	input wire logic nPortOeU,
	input wire logic nPortWeL,
	input wire logic nPortWeU,
	input wire logic nWrL,
	input wire logic nWrU,
	input wire logic nWwL,
	input wire logic nWwU,
	input wire logic nSramOeL,
	input wire logic nSramOeU,
	input wire logic nSramWeL,
	input wire logic nSramWeU,
	input wire logic nLspOe,
	input wire logic nLspWe,
	input wire logic nCrdO,
	input wire logic nCrdW
);

	// Acknowledge must be gone one clock after the strobe ends
	dtackRelease: assert property (@(posedge clk68k) disable iff (rst)
		(nAs && $past(nAs)) |-> nDtack)
		else $error("nDtack low after nAs stayed high for two clocks");

	rdWrExclusive: assert property (@(posedge clk68k) disable iff (rst)
		(nPortOeL | nPortWeL) && (nPortOeU | nPortWeU) &&
		(nWrL | nWwL) && (nWrU | nWwU) &&
		(nSramOeL | nSramWeL) && (nSramOeU | nSramWeU) &&
		(nLspOe | nLspWe) && (nCrdO | nCrdW))
		else $error("read and write enable of one device active together");

	oeOnlyOnRead: assert property (@(posedge clk68k) disable iff (rst)
		!rw |-> !m68kDataOe)
		else $error("data bus driven during a write cycle");

endmodule

bind neoC1 neoC1_chk neoC1_chk_i (.*);

`default_nettype wire

// ==== dv/neoC1Tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module neoC1Tb import c1Pkg::*; ();

	// Active-enable masks, one bit per strobe of the vector below
	localparam logic [26:0] ROML = 27'd1 << 0, ROMU = 27'd1 << 1;
	localparam logic [26:0] POEL = 27'd1 << 2, POEU = 27'd1 << 3;
	localparam logic [26:0] PWEL = 27'd1 << 4, PWEU = 27'd1 << 5, PADR = 27'd1 << 6;
	localparam logic [26:0] WRL = 27'd1 << 7, WRU = 27'd1 << 8;
	localparam logic [26:0] WWL = 27'd1 << 9, WWU = 27'd1 << 10;
	localparam logic [26:0] SROL = 27'd1 << 11, SROU = 27'd1 << 12;
	localparam logic [26:0] SRAL = 27'd1 << 13, SRAU = 27'd1 << 14;
	localparam logic [26:0] SRWL = 27'd1 << 15, SRWU = 27'd1 << 16;
	localparam logic [26:0] LSPO = 27'd1 << 17, LSPW = 27'd1 << 18;
	localparam logic [26:0] CRDO = 27'd1 << 19, CRDW = 27'd1 << 20, CRDC = 27'd1 << 21;
	localparam logic [26:0] DIP0 = 27'd1 << 22, DIP1 = 27'd1 << 23;
	localparam logic [26:0] BITW0 = 27'd1 << 24, BITW1 = 27'd1 << 25, PAL = 27'd1 << 26;
	localparam logic [26:0] PRD = POEL | POEU | PADR;  // Full cartridge read
	localparam logic [26:0] PWR = PWEL | PWEU | PADR;

	// Joypad levels for rows that do not read a joypad
	localparam joy_t PAD1 = 10'h2a5;
	localparam joy_t PAD2 = 10'h15a;

	typedef struct {
		string name;
		logic [7:0] addr;
		logic rwV, udsV, ldsV;
		logic [7:0] dataIn;
		joy_t p1V, p2V;
		logic romWaitV, pw1V, pw0V, backPressure;
		logic [26:0] actMask;
		logic oeExp;
		logic [7:0] dataExp, sndExp;
		int latExp;
	} row_t;

	logic clk68k, rst, rw, nAs, nUds, nLds, m68kDataOe, nDtack;
	addrHi_t m68kAddr;
	byte_t m68kDataIn, m68kDataOut, soundReply, soundCmd;
	joy_t p1In, p2In;
	logic nCd1, nCd2, nWp, nRomWait, nPWait0, nPWait1, pDtack;
	logic nRomOeL, nRomOeU, nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs;
	logic nWrL, nWrU, nWwL, nWwU, nSromOeL, nSromOeU, nSramOeL, nSramOeU;
	logic nSramWeL, nSramWeU, nLspOe, nLspWe, nCrdO, nCrdW, nCrdC;
	logic nDipRd0, nDipRd1, nBitW0, nBitW1, nPal;
	logic [26:0] strobes;
	row_t rows[$];
	int errors = 0;
	integer seed = 32'h22e8_244a;

	neoC1 neoC1_i (.*);

	assign strobes = {nPal, nBitW1, nBitW0, nDipRd1, nDipRd0, nCrdC, nCrdW, nCrdO,
		nLspWe, nLspOe, nSramWeU, nSramWeL, nSramOeU, nSramOeL, nSromOeU, nSromOeL,
		nWwU, nWwL, nWrU, nWrL, nPortAdrs, nPortWeU, nPortWeL, nPortOeU, nPortOeL,
		nRomOeU, nRomOeL};

	initial begin
		clk68k = 1'b0;
		forever #10 clk68k = ~clk68k;
	end

	task automatic checkVal(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s %s expected %h actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic addRow(input string name, input logic [7:0] addr, input logic rwV,
			input logic udsV, input logic ldsV, input logic [7:0] dataIn,
			input joy_t p1V, input joy_t p2V,
			input logic romWaitV, input logic pw1V, input logic pw0V, input logic bp,
			input logic [26:0] actMask, input logic oeExp, input logic [7:0] dataExp,
			input logic [7:0] sndExp, input int latExp);
		row_t r;
		r = '{name, addr, rwV, udsV, ldsV, dataIn, p1V, p2V, romWaitV, pw1V, pw0V, bp,
			actMask, oeExp, dataExp, sndExp, latExp};
		rows.push_back(r);
	endtask

	task automatic runRow(input row_t r);
		int edges;
		int bpCycles;
		int latExp;
		int t;
		bpCycles = r.backPressure ? ({$random(seed)} % 4) + 1 : 0;
		latExp = (bpCycles + 1 > r.latExp) ? bpCycles + 1 : r.latExp;
		@(negedge clk68k);
		m68kAddr = r.addr;
		rw = r.rwV;
		nUds = r.udsV;
		nLds = r.ldsV;
		m68kDataIn = r.dataIn;
		p1In = r.p1V;
		p2In = r.p2V;
		nRomWait = r.romWaitV;
		nPWait1 = r.pw1V;
		nPWait0 = r.pw0V;
		pDtack = !r.backPressure;
		repeat (3) @(negedge clk68k);
		checkVal(r.name, "idle strobes", {5'd0, 27'h7ffffff}, {5'd0, strobes});
		nAs = 1'b0;
		#2;
		checkVal(r.name, "strobes", {5'd0, ~r.actMask}, {5'd0, strobes});
		checkVal(r.name, "dataOe", {31'd0, r.oeExp}, {31'd0, m68kDataOe});
		if (r.oeExp)
			checkVal(r.name, "readData", {24'd0, r.dataExp}, {24'd0, m68kDataOut});
		edges = 0;
		while (nDtack && edges < 20) begin
			@(negedge clk68k);
			edges++;
			if (edges == bpCycles + 1)
				pDtack = 1'b1;  // End of cartridge back-pressure
		end
		if (nDtack) begin
			$display("Timeout: %s never saw nDtack go low", r.name);
			errors++;
		end
		checkVal(r.name, "latency", latExp, edges - 1);
		nAs = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		pDtack = 1'b1;
		t = 0;
		while (!nDtack && t < 20) begin
			@(negedge clk68k);
			t++;
		end
		if (!nDtack) begin
			$display("Timeout: %s nDtack stuck low after the cycle", r.name);
			errors++;
		end
		checkVal(r.name, "soundCmd", {24'd0, r.sndExp}, {24'd0, soundCmd});
	endtask

	initial begin
		rst = 1'b1;
		m68kAddr = '0;
		rw = 1'b1;
		nAs = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		m68kDataIn = '0;
		p1In = PAD1;
		p2In = PAD2;
		nCd1 = 1'b0;
		nCd2 = 1'b0;
		nWp = 1'b1;
		soundReply = 8'h96;
		nRomWait = 1'b1;
		nPWait0 = 1'b1;
		nPWait1 = 1'b1;
		pDtack = 1'b1;
		// name addr rw uds lds din p1 p2 romW pw1 pw0 bp mask oe dout snd lat
		addRow("romRd", 8'h00, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, ROML | ROMU, 0, 0, 0, 1);
		addRow("romRdWait", 8'h02, 1, 0, 0, 0, PAD1, PAD2, 0, 1, 1, 0, ROML | ROMU, 0, 0, 0, 2);
		addRow("wramWr", 8'h08, 0, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, WWL | WWU, 0, 0, 0, 1);
		addRow("wramRd", 8'h0a, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, WRL | WRU, 0, 0, 0, 1);
		addRow("wramRdL", 8'h0c, 1, 1, 0, 0, PAD1, PAD2, 1, 1, 1, 0, WRL, 0, 0, 0, 1);
		addRow("portW0", 8'h10, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, PRD, 0, 0, 0, 1);
		addRow("portW1", 8'h11, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 0, 0, PRD, 0, 0, 0, 2);
		addRow("portW2", 8'h12, 0, 0, 0, 0, PAD1, PAD2, 1, 0, 1, 0, PWR, 0, 0, 0, 3);
		addRow("portW3", 8'h17, 0, 0, 0, 0, PAD1, PAD2, 1, 0, 0, 0, PWR, 0, 0, 0, 4);
		addRow("sromRd", 8'hc0, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, SROL | SROU, 0, 0, 0, 1);
		addRow("sramWr", 8'hc8, 0, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, SRWL | SRWU, 0, 0, 0, 1);
		addRow("sramRd", 8'hca, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, SRAL | SRAU, 0, 0, 0, 1);
		addRow("palRdU", 8'h40, 1, 0, 1, 0, PAD1, PAD2, 1, 1, 1, 0, PAL, 0, 0, 0, 1);
		addRow("cardRd", 8'h80, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, CRDO | CRDC, 0, 0, 0, 1);
		addRow("cardRdByte", 8'h80, 1, 0, 1, 0, PAD1, PAD2, 1, 1, 1, 0, 27'd0, 0, 0, 0, 1);
		addRow("cardWr", 8'hbf, 0, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, CRDW | CRDC, 0, 0, 0, 1);
		addRow("lspWr", 8'h1e, 0, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, LSPW, 0, 0, 0, 1);
		addRow("lspRd", 8'h1e, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 0, LSPO, 0, 0, 0, 1);
		addRow("lspWrByte", 8'h1e, 0, 1, 0, 0, PAD1, PAD2, 1, 1, 1, 0, 27'd0, 0, 0, 0, 1);
		addRow("ctrl1Rd", 8'h18, 1, 0, 1, 0, 10'h1c3, PAD2, 1, 1, 1, 0, 27'd0, 1, 8'hc3, 0, 1);
		addRow("ctrl2Rd", 8'h1a, 1, 0, 1, 0, PAD1, 10'h0e1, 1, 1, 1, 0, 27'd0, 1, 8'he1, 0, 1);
		addRow("statusRd", 8'h1c, 1, 0, 1, 0, 10'h1ff, 10'h2ff, 1, 1, 1, 0, 27'd0, 1, 8'hc9,
			0, 1);
		addRow("icomWr", 8'h19, 0, 0, 1, 8'h3c, PAD1, PAD2, 1, 1, 1, 0, 27'd0, 0, 0, 8'h3c, 1);
		addRow("icomRd", 8'h19, 1, 0, 1, 0, PAD1, PAD2, 1, 1, 1, 0, 27'd0, 1, 8'h96, 8'h3c, 1);
		addRow("dipRd0", 8'h18, 1, 1, 0, 0, PAD1, PAD2, 1, 1, 1, 0, DIP0, 0, 0, 8'h3c, 1);
		addRow("dipRd1", 8'h19, 1, 1, 0, 0, PAD1, PAD2, 1, 1, 1, 0, DIP1, 0, 0, 8'h3c, 1);
		addRow("bitW1", 8'h1d, 0, 1, 0, 8'h55, PAD1, PAD2, 1, 1, 1, 0, BITW1, 0, 0, 8'h3c, 1);
		addRow("bitW0", 8'h1c, 0, 1, 0, 8'haa, PAD1, PAD2, 1, 1, 1, 0, BITW0, 0, 0, 8'h3c, 1);
		addRow("portBpRd", 8'h10, 1, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 1, PRD, 0, 0, 8'h3c, 1);
		addRow("portBpWr", 8'h14, 0, 0, 0, 0, PAD1, PAD2, 1, 1, 1, 1, PWR, 0, 0, 8'h3c, 1);
		repeat (4) @(negedge clk68k);
		rst = 1'b0;
		foreach (rows[i])
			runRow(rows[i]);
		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/c1Pkg.sv
hdl/c1Decode.sv
hdl/c1Regs.sv
hdl/c1Wait.sv
hdl/neoC1.sv
dv/neoC1_chk.sv
dv/neoC1Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the neoC1 testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module neoC1Tb -f sim.f -o neoC1Sim \
	&& ./obj_dir/neoC1Sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
